/* rtl/tcb_params.svh */
////////////////////
// bus widths, response delay and memory depth for the TCB memory subsystem
// include in any file that sizes a port or a storage array
////////////////////

`ifndef TCB_PARAMS_SVH
`define TCB_PARAMS_SVH

// byte address width, transfers are word aligned
`define TCB_ADR_W 12

// data word width in bits
`define TCB_DAT_W 32

// one enable bit per data byte
`define TCB_BEN_W (`TCB_DAT_W/8)

// cycles from handshake to response
// must be 1 or more
`define TCB_DLY 1

// words in the shared array
// word addresses from this value upward report an error
`define TCB_MEM_DEPTH 256

`endif

/* rtl/tcb_pkg.sv */
////////////////////
// signal types of the tightly coupled bus
// referenced by scoped name from the splitter and both subordinates
////////////////////

`default_nettype none

`include "tcb_params.svh"

package tcb_pkg;

  ////////////////////
  // request fields
  ////////////////////

  // byte address
  typedef logic [`TCB_ADR_W-1:0] tcb_adr_t;

  // write or read data word
  typedef logic [`TCB_DAT_W-1:0] tcb_dat_t;

  // byte enables, bit n covers data bits 8n+7..8n
  typedef logic [`TCB_BEN_W-1:0] tcb_ben_t;

  ////////////////////
  // response payload
  ////////////////////

  // read data and error flag travel together through the delay line
  // write responses use only the error bit
  typedef struct packed {
    tcb_dat_t rdt;
    logic     err;
  } tcb_rsp_t;

endpackage

`default_nettype wire

/* rtl/mem_pkg.sv */
////////////////////
// storage types of the word array and the address to index mapping
// shared by both subordinates and the array itself
////////////////////

`default_nettype none

`include "tcb_params.svh"

package mem_pkg;

  // byte offset bits dropped from a bus address
  localparam int unsigned OFS_W = $clog2(`TCB_BEN_W);
  // width of a full word address
  localparam int unsigned WADR_W = `TCB_ADR_W - OFS_W;

  // word index into the array
  typedef logic [$clog2(`TCB_MEM_DEPTH)-1:0] mem_idx_t;

  // one stored word, same width as bus data
  typedef tcb_pkg::tcb_dat_t mem_word_t;

  // low word address bits select the array entry
  function automatic mem_idx_t adr2idx(tcb_pkg::tcb_adr_t adr);
    return adr[OFS_W +: $bits(mem_idx_t)];
  endfunction

  // the full word address must fall below the array depth
  function automatic logic adr_ok(tcb_pkg::tcb_adr_t adr);
    return adr[`TCB_ADR_W-1:OFS_W] < WADR_W'(`TCB_MEM_DEPTH);
  endfunction

endpackage

`default_nettype wire

/* rtl/tcb_dly_pipe.sv */
////////////////////
// fixed delay line of TCB_DLY register stages
// the payload type is a parameter so one block carries read flags,
// read responses and write status alike
////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "tcb_params.svh"

module tcb_dly_pipe #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_n,
  input  T     din,
  output T     dout
);

  ////////////////////
  // stage registers
  ////////////////////

  // stage 0 takes din, the last stage drives dout
  T dly_q [`TCB_DLY];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // all stages empty after reset
      for (int i = 0; i < `TCB_DLY; i++) begin
        dly_q[i] <= '0;
      end
    end else begin
      dly_q[0] <= din;
      // shift toward the output
      for (int i = 1; i < `TCB_DLY; i++) begin
        dly_q[i] <= dly_q[i-1];
      end
    end
  end

  // oldest stage
  assign dout = dly_q[`TCB_DLY-1];

endmodule

`default_nettype wire

/* rtl/tcb_common2independent.sv */
////////////////////
// splits a common read/write TCB channel into separate read and write channels
// requests are steered by wen, responses are picked by a delayed read flag
// place between one manager and a pair of read and write subordinates
////////////////////

`default_nettype none
`timescale 1ns/1ns

module tcb_common2independent (
  input  logic               clk,
  input  logic               rst_n,
  // common channel, manager side
  input  logic               crw_vld,
  input  logic               crw_wen,
  input  tcb_pkg::tcb_adr_t  crw_adr,
  input  tcb_pkg::tcb_ben_t  crw_ben,
  input  tcb_pkg::tcb_dat_t  crw_wdt,
  output logic               crw_rdy,
  output tcb_pkg::tcb_dat_t  crw_rsp_rdt,
  output logic               crw_rsp_err,
  // read channel
  output logic               rdc_vld,
  output tcb_pkg::tcb_adr_t  rdc_adr,
  input  logic               rdc_rdy,
  input  tcb_pkg::tcb_dat_t  rdc_rsp_rdt,
  input  logic               rdc_rsp_err,
  // write channel
  output logic               wrc_vld,
  output tcb_pkg::tcb_adr_t  wrc_adr,
  output tcb_pkg::tcb_ben_t  wrc_ben,
  output tcb_pkg::tcb_dat_t  wrc_wdt,
  input  logic               wrc_rdy,
  input  logic               wrc_rsp_err
);

  // read accepted this cycle
  logic ren;
  // read flag aligned with the returning response
  logic ren_dly;

  ////////////////////
  // request path
  ////////////////////

  // valid goes only to the channel picked by wen
  assign rdc_vld = crw_vld & ~crw_wen;
  assign wrc_vld = crw_vld &  crw_wen;

  // ready comes back from the same channel
  assign crw_rdy = crw_wen ? wrc_rdy : rdc_rdy;

  // read side needs only the address
  assign rdc_adr = crw_adr;

  // write side gets address, enables and data
  assign wrc_adr = crw_adr;
  assign wrc_ben = crw_ben;
  assign wrc_wdt = crw_wdt;

  ////////////////////
  // response path
  ////////////////////

  // flag is set only on a read handshake
  // a stalled request puts nothing in the pipe
  assign ren = crw_vld & ~crw_wen & crw_rdy;

  tcb_dly_pipe #(
    .T (logic)
  ) u_ren_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (ren),
    .dout  (ren_dly)
  );

  // write channel returns no data, zero stands in for it
  assign crw_rsp_rdt = ren_dly ? rdc_rsp_rdt : '0;
  // idle cycles show the write channel, which is zero when idle
  assign crw_rsp_err = ren_dly ? rdc_rsp_err : wrc_rsp_err;

endmodule

`default_nettype wire

/* rtl/tcb_mem_rd.sv */
////////////////////
// read subordinate on the read-only TCB channel
// reads the array in the handshake cycle and returns data TCB_DLY later
////////////////////

`default_nettype none
`timescale 1ns/1ns

module tcb_mem_rd (
  input  logic                clk,
  input  logic                rst_n,
  // read channel
  input  logic                vld,
  input  tcb_pkg::tcb_adr_t   adr,
  output logic                rdy,
  output tcb_pkg::tcb_dat_t   rsp_rdt,
  output logic                rsp_err,
  // array read port
  output mem_pkg::mem_idx_t   mem_idx,
  input  mem_pkg::mem_word_t  mem_rdata
);

  // handshake this cycle
  logic hs;
  // address inside the array
  logic adr_ok;
  // response entering and leaving the pipe
  tcb_pkg::tcb_rsp_t rsp_d;
  tcb_pkg::tcb_rsp_t rsp_q;

  // never stalls
  assign rdy = 1'b1;
  assign hs  = vld & rdy;

  // word index and range check from the byte address
  assign mem_idx = mem_pkg::adr2idx(adr);
  assign adr_ok  = mem_pkg::adr_ok(adr);

  // data only for a good read
  // out of range gives zero data with err
  // no handshake gives an all zero entry
  assign rsp_d.rdt = (hs && adr_ok) ? mem_rdata : '0;
  assign rsp_d.err = hs & ~adr_ok;

  tcb_dly_pipe #(
    .T (tcb_pkg::tcb_rsp_t)
  ) u_rsp_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (rsp_d),
    .dout  (rsp_q)
  );

  assign rsp_rdt = rsp_q.rdt;
  assign rsp_err = rsp_q.err;

endmodule

`default_nettype wire

/* rtl/tcb_mem_wr.sv */
////////////////////
// write subordinate on the write-only TCB channel
// writes the array on the handshake edge and returns status TCB_DLY later
////////////////////

`default_nettype none
`timescale 1ns/1ns

module tcb_mem_wr (
  input  logic                clk,
  input  logic                rst_n,
  // write channel
  input  logic                vld,
  input  tcb_pkg::tcb_adr_t   adr,
  input  tcb_pkg::tcb_ben_t   ben,
  input  tcb_pkg::tcb_dat_t   wdt,
  output logic                rdy,
  output logic                rsp_err,
  // array write port
  output logic                mem_we,
  output mem_pkg::mem_idx_t   mem_idx,
  output tcb_pkg::tcb_ben_t   mem_ben,
  output mem_pkg::mem_word_t  mem_wdata
);

  // handshake this cycle
  logic hs;
  // address inside the array
  logic adr_ok;
  // error bit entering the pipe
  logic err_d;

  // never stalls
  assign rdy = 1'b1;
  assign hs  = vld & rdy;

  assign adr_ok = mem_pkg::adr_ok(adr);

  // write strobe only for a good address
  // a bad address leaves the array untouched
  assign mem_we    = hs & adr_ok;
  assign mem_idx   = mem_pkg::adr2idx(adr);
  assign mem_ben   = ben;
  assign mem_wdata = wdt;

  // status is err for a bad address, zero otherwise
  assign err_d = hs & ~adr_ok;

  tcb_dly_pipe #(
    .T (logic)
  ) u_err_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (err_d),
    .dout  (rsp_err)
  );

endmodule

`default_nettype wire

/* rtl/tcb_mem_array.sv */
////////////////////
// word storage with one byte-enabled write port and one combinational read port
// write data shows on the read port from the cycle after the write edge
////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "tcb_params.svh"

module tcb_mem_array (
  input  logic                clk,
  // write port
  input  logic                we,
  input  mem_pkg::mem_idx_t   widx,
  input  tcb_pkg::tcb_ben_t   ben,
  input  mem_pkg::mem_word_t  wdata,
  // read port
  input  mem_pkg::mem_idx_t   ridx,
  output mem_pkg::mem_word_t  rdata
);

  ////////////////////
  // storage
  ////////////////////

  // contents are undefined until written
  mem_pkg::mem_word_t mem [`TCB_MEM_DEPTH];

  // each enabled byte lane is updated on its own
  always_ff @(posedge clk) begin
    if (we) begin
      for (int b = 0; b < `TCB_BEN_W; b++) begin
        if (ben[b]) begin
          mem[widx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // asynchronous read
  assign rdata = mem[ridx];

endmodule

`default_nettype wire

/* rtl/tcb_mem_sys.sv */
////////////////////
// TCB memory subsystem top level
// one common read/write channel in front of a splitter,
// separate read and write subordinates and one shared word array
////////////////////

`default_nettype none
`timescale 1ns/1ns

module tcb_mem_sys (
  input  logic               clk,
  input  logic               rst_n,
  // common channel
  input  logic               crw_vld,
  input  logic               crw_wen,
  input  tcb_pkg::tcb_adr_t  crw_adr,
  input  tcb_pkg::tcb_ben_t  crw_ben,
  input  tcb_pkg::tcb_dat_t  crw_wdt,
  output logic               crw_rdy,
  output tcb_pkg::tcb_dat_t  crw_rsp_rdt,
  output logic               crw_rsp_err
);

  // read channel
  logic               rdc_vld;
  tcb_pkg::tcb_adr_t  rdc_adr;
  logic               rdc_rdy;
  tcb_pkg::tcb_dat_t  rdc_rsp_rdt;
  logic               rdc_rsp_err;

  // write channel
  logic               wrc_vld;
  tcb_pkg::tcb_adr_t  wrc_adr;
  tcb_pkg::tcb_ben_t  wrc_ben;
  tcb_pkg::tcb_dat_t  wrc_wdt;
  logic               wrc_rdy;
  logic               wrc_rsp_err;

  // array ports
  logic               mem_we;
  mem_pkg::mem_idx_t  mem_widx;
  tcb_pkg::tcb_ben_t  mem_ben;
  mem_pkg::mem_word_t mem_wdata;
  mem_pkg::mem_idx_t  mem_ridx;
  mem_pkg::mem_word_t mem_rdata;

  ////////////////////
  // channel split
  ////////////////////

  tcb_common2independent u_split (
    .clk         (clk),
    .rst_n       (rst_n),
    .crw_vld     (crw_vld),
    .crw_wen     (crw_wen),
    .crw_adr     (crw_adr),
    .crw_ben     (crw_ben),
    .crw_wdt     (crw_wdt),
    .crw_rdy     (crw_rdy),
    .crw_rsp_rdt (crw_rsp_rdt),
    .crw_rsp_err (crw_rsp_err),
    .rdc_vld     (rdc_vld),
    .rdc_adr     (rdc_adr),
    .rdc_rdy     (rdc_rdy),
    .rdc_rsp_rdt (rdc_rsp_rdt),
    .rdc_rsp_err (rdc_rsp_err),
    .wrc_vld     (wrc_vld),
    .wrc_adr     (wrc_adr),
    .wrc_ben     (wrc_ben),
    .wrc_wdt     (wrc_wdt),
    .wrc_rdy     (wrc_rdy),
    .wrc_rsp_err (wrc_rsp_err)
  );

  ////////////////////
  // subordinates and storage
  ////////////////////

  tcb_mem_rd u_rd (
    .clk       (clk),
    .rst_n     (rst_n),
    .vld       (rdc_vld),
    .adr       (rdc_adr),
    .rdy       (rdc_rdy),
    .rsp_rdt   (rdc_rsp_rdt),
    .rsp_err   (rdc_rsp_err),
    .mem_idx   (mem_ridx),
    .mem_rdata (mem_rdata)
  );

  tcb_mem_wr u_wr (
    .clk       (clk),
    .rst_n     (rst_n),
    .vld       (wrc_vld),
    .adr       (wrc_adr),
    .ben       (wrc_ben),
    .wdt       (wrc_wdt),
    .rdy       (wrc_rdy),
    .rsp_err   (wrc_rsp_err),
    .mem_we    (mem_we),
    .mem_idx   (mem_widx),
    .mem_ben   (mem_ben),
    .mem_wdata (mem_wdata)
  );

  tcb_mem_array u_mem (
    .clk   (clk),
    .we    (mem_we),
    .widx  (mem_widx),
    .ben   (mem_ben),
    .wdata (mem_wdata),
    .ridx  (mem_ridx),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

/* verif/tcb_mem_sys_tb.sv */
////////////////////
// testbench for the TCB memory subsystem
// drives the common channel on falling edges, keeps a reference memory
// and compares every response on its due cycle
////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "tcb_params.svh"

module tcb_mem_sys_tb;

  localparam int ADR_W = `TCB_ADR_W;
  localparam int DAT_W = `TCB_DAT_W;
  localparam int BEN_W = `TCB_BEN_W;
  localparam int DLY = `TCB_DLY;
  localparam int DEPTH = `TCB_MEM_DEPTH;
  localparam int IDX_W = $clog2(DEPTH);
  localparam int OFS = $clog2(BEN_W);
  localparam int WADR_N = 2 ** (ADR_W - OFS);
  localparam bit [31:0] SEED = 32'heda6;
  localparam int RST_CYC = 5;
  // transfer counts per test phase
  localparam int N_DIR = 16;
  localparam int N_BEN = 16;
  localparam int N_OOR = 8;
  localparam int N_RAND = 300;
  localparam int N_XFER = DEPTH + 2 * N_DIR + 2 * N_BEN + 3 * N_OOR + N_RAND;
  // each transfer takes at most one idle cycle plus its own
  localparam int ISSUE_CYC = RST_CYC + 2 * N_XFER + 10;
  localparam int CYC_LIMIT = 2 * ISSUE_CYC + 100;

  logic clk = 1'b0;
  logic rst_n;
  logic crw_vld;
  logic crw_wen;
  logic [ADR_W-1:0] crw_adr;
  logic [BEN_W-1:0] crw_ben;
  logic [DAT_W-1:0] crw_wdt;
  logic crw_rdy;
  logic [DAT_W-1:0] crw_rsp_rdt;
  logic crw_rsp_err;

  // reference memory and expected responses in issue order
  logic [DAT_W-1:0] ref_mem [DEPTH];
  tcb_pkg::tcb_rsp_t exp_q [$];
  int due_q [$];
  tcb_pkg::tcb_rsp_t rsp_exp;
  int cyc = 0;
  int unsigned wadr;

  tcb_mem_sys UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .crw_vld     (crw_vld),
    .crw_wen     (crw_wen),
    .crw_adr     (crw_adr),
    .crw_ben     (crw_ben),
    .crw_wdt     (crw_wdt),
    .crw_rdy     (crw_rdy),
    .crw_rsp_rdt (crw_rsp_rdt),
    .crw_rsp_err (crw_rsp_err)
  );

  always #20 clk = ~clk;

  ////////////////////
  // helpers
  ////////////////////

  task automatic compare_val(input string name, input logic [DAT_W-1:0] got,
                             input logic [DAT_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // word address shifted up to a byte address
  function automatic logic [ADR_W-1:0] byte_adr(input int unsigned wa);
    return ADR_W'(wa << OFS);
  endfunction

  // preload pattern that depends on every address bit
  function automatic logic [DAT_W-1:0] fill_word(input int unsigned wa);
    return (DAT_W'(wa) * 32'h9e37_79b1) ^ 32'ha5c3_0f1e;
  endfunction

  // expected response of one accepted transfer
  // writes also update the model
  function automatic tcb_pkg::tcb_rsp_t expected_rsp(input logic wen,
      input logic [ADR_W-1:0] adr, input logic [BEN_W-1:0] ben,
      input logic [DAT_W-1:0] wdt);
    tcb_pkg::tcb_rsp_t rsp;
    int unsigned wa;
    logic [IDX_W-1:0] idx;
    rsp = '0;
    wa = 32'(adr) >> OFS;
    idx = IDX_W'(wa);
    if (wa >= DEPTH) begin
      // no storage behind this address so data stays zero
      rsp.err = 1'b1;
    end else if (wen) begin
      for (int b = 0; b < BEN_W; b++) begin
        if (ben[b]) begin
          ref_mem[idx][8*b +: 8] = wdt[8*b +: 8];
        end
      end
    end else begin
      rsp.rdt = ref_mem[idx];
    end
    return rsp;
  endfunction

  // one transfer held until its handshake edge
  task automatic issue(input logic wen, input logic [ADR_W-1:0] adr,
                       input logic [BEN_W-1:0] ben, input logic [DAT_W-1:0] wdt);
    logic done;
    done = 1'b0;
    @(negedge clk);
    crw_vld = 1'b1;
    crw_wen = wen;
    crw_adr = adr;
    crw_ben = ben;
    crw_wdt = wdt;
    while (!done) begin
      @(posedge clk);
      if (crw_rdy) begin
        exp_q.push_back(expected_rsp(wen, adr, ben, wdt));
        due_q.push_back(cyc + DLY);
        done = 1'b1;
      end
    end
  endtask

  // vld low with random don't care fields
  task automatic idle_cycle();
    @(negedge clk);
    crw_vld = 1'b0;
    crw_wen = 1'($urandom);
    crw_adr = ADR_W'($urandom);
    crw_wdt = $urandom;
  endtask

  ////////////////////
  // cycle count and timeout
  ////////////////////

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYC_LIMIT) begin
      $display("timeout: test did not finish within %0d cycles", CYC_LIMIT);
      $display("Errors found");
      $fatal(1, "cycle limit reached");
    end
  end

  ////////////////////
  // response compare
  ////////////////////

  // responses are sampled mid cycle on the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (due_q.size() != 0 && due_q[0] == cyc) begin
        rsp_exp = exp_q.pop_front();
        void'(due_q.pop_front());
        compare_val("crw_rsp_rdt", crw_rsp_rdt, rsp_exp.rdt);
        compare_val("crw_rsp_err", DAT_W'(crw_rsp_err), DAT_W'(rsp_exp.err));
      end else begin
        // idle cycles show zero
        compare_val("crw_rsp_rdt", crw_rsp_rdt, '0);
        compare_val("crw_rsp_err", DAT_W'(crw_rsp_err), '0);
      end
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    void'($urandom(SEED));
    rst_n = 1'b0;
    // an out of range read offered during reset must not reach any pipe
    crw_vld = 1'b1;
    crw_wen = 1'b0;
    crw_adr = byte_adr(DEPTH);
    crw_ben = '0;
    crw_wdt = '0;
    repeat (RST_CYC) @(negedge clk);
    compare_val("crw_rsp_rdt", crw_rsp_rdt, '0);
    compare_val("crw_rsp_err", DAT_W'(crw_rsp_err), '0);
    rst_n = 1'b1;
    crw_vld = 1'b0;
    @(negedge clk);
    compare_val("crw_rdy", DAT_W'(crw_rdy), 1);
    compare_val("crw_rsp_rdt", crw_rsp_rdt, '0);
    compare_val("crw_rsp_err", DAT_W'(crw_rsp_err), '0);
    // preload every word with a known pattern
    for (int i = 0; i < DEPTH; i++) begin
      issue(1'b1, byte_adr(i), '1, fill_word(i));
    end
    // full word writes followed by reads of the same words
    for (int i = 0; i < N_DIR; i++) begin
      issue(1'b1, byte_adr((i * 37 + 5) % DEPTH), '1, $urandom);
    end
    for (int i = 0; i < N_DIR; i++) begin
      issue(1'b0, byte_adr((i * 37 + 5) % DEPTH), '0, '0);
    end
    // partial writes each followed by a read of the same word
    for (int i = 0; i < N_BEN; i++) begin
      wadr = (i * 13 + 2) % DEPTH;
      if (i < BEN_W) begin
        issue(1'b1, byte_adr(wadr), BEN_W'(1 << i), $urandom);
      end else begin
        issue(1'b1, byte_adr(wadr), BEN_W'($urandom), $urandom);
      end
      issue(1'b0, byte_adr(wadr), '0, '0);
    end
    // out of range write and read followed by a read of the aliased word
    for (int i = 0; i < N_OOR; i++) begin
      wadr = DEPTH * (1 + i % 3) + i * 11;
      issue(1'b1, byte_adr(wadr), '1, $urandom);
      issue(1'b0, byte_adr(wadr), '0, '0);
      issue(1'b0, byte_adr(wadr % DEPTH), '0, '0);
    end
    // mixed traffic on a small window so reads hit fresh writes
    for (int i = 0; i < N_RAND; i++) begin
      if ($urandom % 4 == 0) begin
        idle_cycle();
      end
      if ($urandom % 8 == 0) begin
        wadr = DEPTH + $urandom % (WADR_N - DEPTH);
      end else begin
        wadr = $urandom % 32;
      end
      issue(1'($urandom), byte_adr(wadr), BEN_W'($urandom), $urandom);
    end
    idle_cycle();
    while (due_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/tcb_pkg.sv
rtl/mem_pkg.sv
rtl/tcb_dly_pipe.sv
rtl/tcb_common2independent.sv
rtl/tcb_mem_rd.sv
rtl/tcb_mem_wr.sv
rtl/tcb_mem_array.sv
rtl/tcb_mem_sys.sv
verif/tcb_mem_sys_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the TCB memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tcb_mem_sys_tb \
  -Mdir obj_dir -o tcb_mem_sys_tb
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

out=$(./obj_dir/tcb_mem_sys_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "No errors"; then
  exit 0
else
  echo "pass message not found in simulation output"
  exit 1
fi
